// File: flist.f
logic/fix_proto_pkg.sv
logic/fix_xfer_pkg.sv
logic/fix_checksum_acc.sv
logic/fix_field_serializer.sv
logic/fix_byte_fifo.sv
logic/fix_stream_drain.sv
logic/fix_msg_tx.sv
verification/fix_msg_tx_tb.sv

// File: logic/fix_byte_fifo.sv
// circular buffer of stream entries between serializer and drain
`timescale 1ns/10ps

module fix_byte_fifo #(
	parameter int DEPTH = 16
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     push_i,
	input  fix_xfer_pkg::fix_entry_t entry_i,
	output logic                     full_o,
	input  logic                     pop_i,
	output fix_xfer_pkg::fix_entry_t head_o,
	output logic                     empty_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	fix_xfer_pkg::fix_entry_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	// storage only, no reset needed
	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wr_ptr] <= entry_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_o = mem[rd_ptr];
	assign full_o = (count == CW'(DEPTH));
	assign empty_o = (count == '0);

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) full_o |-> !push_i)
		else $error("push into full FIFO at %0t", $time);

	a_no_underflow: assert property (@(posedge clk) disable iff (rst) empty_o |-> !pop_i)
		else $error("pop from empty FIFO at %0t", $time);

endmodule

// File: logic/fix_checksum_acc.sv
// modulo-256 running byte sum with ascii decimal output, used by the field serializer
`timescale 1ns/10ps

module fix_checksum_acc (
	input  logic        clk,
	input  logic        rst,
	input  logic        add_i,
	input  logic [7:0]  byte_i,
	input  logic        clear_i,
	output logic [23:0] digits_o
);

	logic [7:0] sum_q;

	// clear wins over add
	always_ff @(posedge clk) begin
		if (rst) begin
			sum_q <= 8'd0;
		end else if (clear_i) begin
			sum_q <= 8'd0;
		end else if (add_i) begin
			sum_q <= sum_q + byte_i;
		end
	end

	// binary to three decimal digits by repeated subtraction
	always_comb begin
		logic [7:0] rem;
		logic [7:0] hund;
		logic [7:0] tens;

		rem = sum_q;
		hund = 8'd0;
		tens = 8'd0;

		// at most two hundreds in 255
		for (int i = 0; i < 2; i++) begin
			if (rem >= 8'd100) begin
				rem = rem - 8'd100;
				hund = hund + 8'd1;
			end
		end

		// at most nine tens left
		for (int i = 0; i < 9; i++) begin
			if (rem >= 8'd10) begin
				rem = rem - 8'd10;
				tens = tens + 8'd1;
			end
		end

		// hundreds first
		digits_o[23:16] = fix_proto_pkg::ASCII_ZERO + hund;
		digits_o[15:8] = fix_proto_pkg::ASCII_ZERO + tens;
		digits_o[7:0] = fix_proto_pkg::ASCII_ZERO + rem;
	end

endmodule

// File: logic/fix_field_serializer.sv
// turns one field per four-phase handshake into FIFO bytes, appending the checksum trailer
`timescale 1ns/10ps

module fix_field_serializer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      field_req_i,
	input  fix_proto_pkg::fix_field_t field_i,
	output logic                      field_ack_o,
	output logic                      push_o,
	output fix_xfer_pkg::fix_entry_t  entry_o,
	input  logic                      full_i
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_TAG,
		S_EQ,
		S_VAL,
		S_SOH,
		S_T1,
		S_T0,
		S_TEQ,
		S_D2,
		S_D1,
		S_D0,
		S_TSOH,
		S_ACK
	} state_t;

	state_t state_q;
	state_t state_d;

	// byte position within tag or value
	logic [3:0] idx_q;
	logic [3:0] idx_d;

	logic emit;
	logic [23:0] digits;

	fix_checksum_acc cksum_inst (
		.clk      (clk),
		.rst      (rst),
		.add_i    (push_o && (state_q inside {S_TAG, S_EQ, S_VAL, S_SOH})),
		.byte_i   (entry_o.data),
		.clear_i  (push_o && (state_q == S_TSOH)),
		.digits_o (digits)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_IDLE;
			idx_q <= 4'd0;
		end else begin
			state_q <= state_d;
			idx_q <= idx_d;
		end
	end

	// byte selection per phase
	always_comb begin
		emit = 1'b1;
		entry_o.data = 8'h00;
		entry_o.eom = 1'b0;
		case (state_q)
			S_TAG: entry_o.data = field_i.tag[idx_q[1:0]];
			S_EQ, S_TEQ: entry_o.data = fix_proto_pkg::EQ;
			S_VAL: entry_o.data = field_i.value[idx_q];
			S_SOH: entry_o.data = fix_proto_pkg::SOH;
			S_T1: entry_o.data = fix_proto_pkg::CKSUM_TAG[15:8];
			S_T0: entry_o.data = fix_proto_pkg::CKSUM_TAG[7:0];
			S_D2: entry_o.data = digits[23:16];
			S_D1: entry_o.data = digits[15:8];
			S_D0: entry_o.data = digits[7:0];
			S_TSOH: begin
				entry_o.data = fix_proto_pkg::SOH;
				entry_o.eom = 1'b1;
			end
			default: emit = 1'b0;
		endcase
	end

	assign push_o = emit && !full_i;
	assign field_ack_o = (state_q == S_ACK);

	always_comb begin
		state_d = state_q;
		idx_d = idx_q;
		case (state_q)
			S_IDLE: begin
				if (field_req_i) begin
					state_d = S_TAG;
					idx_d = 4'd0;
				end
			end
			// hold ack until the request is withdrawn
			S_ACK: begin
				if (!field_req_i) begin
					state_d = S_IDLE;
				end
			end
			default: begin
				// a full FIFO freezes the phase and index
				if (!full_i) begin
					case (state_q)
						S_TAG: begin
							if (idx_q == {1'b0, field_i.tag_len} - 4'd1) begin
								state_d = S_EQ;
								idx_d = 4'd0;
							end else begin
								idx_d = idx_q + 4'd1;
							end
						end
						S_EQ: state_d = S_VAL;
						S_VAL: begin
							if ({1'b0, idx_q} == field_i.value_len - 5'd1) begin
								state_d = S_SOH;
								idx_d = 4'd0;
							end else begin
								idx_d = idx_q + 4'd1;
							end
						end
						S_SOH: state_d = field_i.last ? S_T1 : S_ACK;
						S_T1: state_d = S_T0;
						S_T0: state_d = S_TEQ;
						S_TEQ: state_d = S_D2;
						S_D2: state_d = S_D1;
						S_D1: state_d = S_D0;
						S_D0: state_d = S_TSOH;
						S_TSOH: state_d = S_ACK;
						default: state_d = state_q;
					endcase
				end
			end
		endcase
	end

	// the caller must present sane lengths for the whole open request
	a_field_lengths: assert property (@(posedge clk) disable iff (rst)
		(field_req_i && !field_ack_o) |->
			(field_i.tag_len != 3'd0 && field_i.tag_len <= fix_proto_pkg::TAG_BYTES &&
			 field_i.value_len != 5'd0 && field_i.value_len <= fix_proto_pkg::VALUE_BYTES))
		else $error("field length out of range at %0t", $time);

endmodule

// File: logic/fix_msg_tx.sv
// message transmitter top: field serializer feeding a byte FIFO drained to the output handshake
`timescale 1ns/10ps

module fix_msg_tx #(
	parameter int FIFO_DEPTH = fix_xfer_pkg::FIFO_DEPTH_DEFAULT
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      field_req_i,
	input  fix_proto_pkg::fix_field_t field_i,
	output logic                      field_ack_o,
	output logic                      out_req_o,
	output logic [7:0]                out_byte_o,
	output logic                      out_last_o,
	input  logic                      out_ack_i
);

	// serializer to FIFO
	logic push;
	logic full;
	fix_xfer_pkg::fix_entry_t push_entry;

	// FIFO to drain
	logic pop;
	logic empty;
	fix_xfer_pkg::fix_entry_t head;

	fix_field_serializer serializer_inst (
		.clk         (clk),
		.rst         (rst),
		.field_req_i (field_req_i),
		.field_i     (field_i),
		.field_ack_o (field_ack_o),
		.push_o      (push),
		.entry_o     (push_entry),
		.full_i      (full)
	);

	fix_byte_fifo #(
		.DEPTH (FIFO_DEPTH)
	) fifo_inst (
		.clk     (clk),
		.rst     (rst),
		.push_i  (push),
		.entry_i (push_entry),
		.full_o  (full),
		.pop_i   (pop),
		.head_o  (head),
		.empty_o (empty)
	);

	fix_stream_drain drain_inst (
		.clk        (clk),
		.rst        (rst),
		.empty_i    (empty),
		.head_i     (head),
		.pop_o      (pop),
		.out_req_o  (out_req_o),
		.out_byte_o (out_byte_o),
		.out_last_o (out_last_o),
		.out_ack_i  (out_ack_i)
	);

endmodule

// File: logic/fix_proto_pkg.sv
// message format definitions for the tag=value serializer, referenced by scoped name
package fix_proto_pkg;

	// longest tag and value the serializer accepts
	localparam int TAG_BYTES = 4;
	localparam int VALUE_BYTES = 16;

	// field delimiter and tag/value separator
	localparam logic [7:0] SOH = 8'h01;
	localparam logic [7:0] EQ = 8'h3d;

	// checksum tag "10", upper byte goes out first
	localparam logic [15:0] CKSUM_TAG = 16'h3130;

	// ascii '0', base for the checksum digits
	localparam logic [7:0] ASCII_ZERO = 8'h30;

	// one field as presented on the input handshake
	// byte 0 of tag and value sits in the low bits and is sent first
	typedef struct packed {
		// tag characters
		logic [TAG_BYTES-1:0][7:0] tag;

		// number of tag bytes in use, 1 to 4
		logic [2:0] tag_len;

		// value characters
		logic [VALUE_BYTES-1:0][7:0] value;

		// number of value bytes in use, 1 to 16
		logic [4:0] value_len;

		// closes the message with the checksum trailer
		logic last;
	} fix_field_t;

	// 32 + 3 + 128 + 5 + 1
	localparam int FIELD_BITS = $bits(fix_field_t);

endpackage

// File: logic/fix_stream_drain.sv
// pops FIFO entries and offers each byte on the output four-phase handshake
`timescale 1ns/10ps

module fix_stream_drain (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     empty_i,
	input  fix_xfer_pkg::fix_entry_t head_i,
	output logic                     pop_o,
	output logic                     out_req_o,
	output logic [7:0]               out_byte_o,
	output logic                     out_last_o,
	input  logic                     out_ack_i
);

	typedef enum logic [1:0] {
		D_IDLE,
		D_REQ,
		D_ACK_LOW
	} drain_state_t;

	drain_state_t state_q;

	// take the head as soon as the previous handshake has closed
	assign pop_o = (state_q == D_IDLE || state_q == D_ACK_LOW) && !out_ack_i && !empty_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= D_IDLE;
		end else begin
			case (state_q)
				D_IDLE: if (pop_o) state_q <= D_REQ;
				D_REQ: if (out_ack_i) state_q <= D_ACK_LOW;
				D_ACK_LOW: begin
					if (pop_o) begin
						state_q <= D_REQ;
					end else if (!out_ack_i) begin
						state_q <= D_IDLE;
					end
				end
				default: state_q <= D_IDLE;
			endcase
		end
	end

	// byte under offer, loaded with the pop
	always_ff @(posedge clk) begin
		if (pop_o) begin
			out_byte_o <= head_i.data;
			out_last_o <= head_i.eom;
		end
	end

	assign out_req_o = (state_q == D_REQ);

	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		(out_req_o && $past(out_req_o)) |-> ($stable(out_byte_o) && $stable(out_last_o)))
		else $error("output byte changed under request at %0t", $time);

endmodule

// File: logic/fix_xfer_pkg.sv
// byte stream transport definitions shared by serializer, FIFO and drain
package fix_xfer_pkg;

	// one byte in flight between serializer and drain
	typedef struct packed {
		// the byte itself
		logic [7:0] data;

		// high only on the SOH that ends a message
		logic eom;
	} fix_entry_t;

	// buffer depth used by the top level unless overridden
	localparam int FIFO_DEPTH_DEFAULT = 16;

	// width of one stored entry
	localparam int ENTRY_BITS = $bits(fix_entry_t);

endpackage

// File: verification/fix_msg_tx_tb.sv
// testbench for the message transmitter: drives fields, answers the output handshake, checks bytes
`timescale 1ns/10ps

module fix_msg_tx_tb;

	localparam int RAND_FIELDS = 24;
	localparam int TOTAL_FIELDS = RAND_FIELDS + 2;

	logic clk;
	logic rst;
	logic field_req_i;
	fix_proto_pkg::fix_field_t field_i;
	logic field_ack_o;
	logic out_req_o;
	logic [7:0] out_byte_o;
	logic out_last_o;
	logic out_ack_i;

	// expected stream, {last, byte} per entry
	logic [8:0] exp_q[$];
	int msg_sum;
	int errors;
	int pass_count;
	int fail_count;
	int errs_before;
	logic slow_ack;
	logic [19:0] stim_lfsr;
	logic [19:0] ack_lfsr;

	fix_msg_tx #(
		.FIFO_DEPTH (4)
	) fix_msg_tx_inst (
		.clk         (clk),
		.rst         (rst),
		.field_req_i (field_req_i),
		.field_i     (field_i),
		.field_ack_o (field_ack_o),
		.out_req_o   (out_req_o),
		.out_byte_o  (out_byte_o),
		.out_last_o  (out_last_o),
		.out_ack_i   (out_ack_i)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// x^20 + x^17 + 1
	function automatic logic [19:0] lfsr_next(input logic [19:0] s);
		return {s[18:0], s[19] ^ s[16]};
	endfunction

	task automatic draw_bits(ref logic [19:0] state, input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_next(state);
			val = (val << 1) | state[0];
		end
	endtask

	// append one field, plus the trailer when it closes the message
	task automatic expect_field(input fix_proto_pkg::fix_field_t f);
		logic [7:0] b;
		int s;
		for (int i = 0; i < f.tag_len; i++) begin
			b = f.tag[i];
			exp_q.push_back({1'b0, b});
			msg_sum += b;
		end
		exp_q.push_back({1'b0, 8'h3d});
		msg_sum += 8'h3d;
		for (int i = 0; i < f.value_len; i++) begin
			b = f.value[i];
			exp_q.push_back({1'b0, b});
			msg_sum += b;
		end
		exp_q.push_back({1'b0, 8'h01});
		msg_sum += 8'h01;
		if (f.last) begin
			s = msg_sum % 256;
			exp_q.push_back({1'b0, 8'h31});
			exp_q.push_back({1'b0, 8'h30});
			exp_q.push_back({1'b0, 8'h3d});
			exp_q.push_back({1'b0, 8'(8'h30 + s / 100)});
			exp_q.push_back({1'b0, 8'(8'h30 + (s / 10) % 10)});
			exp_q.push_back({1'b0, 8'(8'h30 + s % 10)});
			exp_q.push_back({1'b1, 8'h01});
			msg_sum = 0;
		end
	endtask

	task automatic send_field(input fix_proto_pkg::fix_field_t f);
		expect_field(f);
		field_i = f;
		field_req_i = 1'b1;
		do begin
			@(posedge clk);
			#2;
		end while (!field_ack_o);
		// request stays up a cycle past the ack, an early ack drop would show
		@(posedge clk);
		#2;
		field_req_i = 1'b0;
		do begin
			@(posedge clk);
			#2;
		end while (field_ack_o);
	endtask

	// random field of ascii digits
	task automatic random_field(input logic force_last, output fix_proto_pkg::fix_field_t f);
		int v;
		f = '0;
		draw_bits(stim_lfsr, 2, v);
		f.tag_len = 3'(v + 1);
		draw_bits(stim_lfsr, 4, v);
		f.value_len = 5'(v + 1);
		for (int i = 0; i < fix_proto_pkg::TAG_BYTES; i++) begin
			draw_bits(stim_lfsr, 4, v);
			f.tag[i] = 8'(8'h30 + v % 10);
		end
		for (int i = 0; i < fix_proto_pkg::VALUE_BYTES; i++) begin
			draw_bits(stim_lfsr, 4, v);
			f.value[i] = 8'(8'h30 + v % 10);
		end
		draw_bits(stim_lfsr, 2, v);
		f.last = force_last || (v == 0);
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0 || out_req_o || out_ack_i) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic close_test(input string name);
		if (errors == errs_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: FAILED with %0d errors", name, errors - errs_before);
		end
		errs_before = errors;
	endtask

	// output side of the four-phase handshake, byte compare on each new request
	initial begin : ack_responder
		int delay;
		logic [8:0] exp_word;
		forever begin
			@(posedge clk);
			#2;
			if (out_req_o && !out_ack_i) begin
				if (exp_q.size() == 0) begin
					$display("extra output byte %02h at %0t with none expected", out_byte_o, $time);
					errors++;
				end else begin
					exp_word = exp_q.pop_front();
					assert ({out_last_o, out_byte_o} == exp_word) else begin
						$display("Mismatch at %0t: expected byte %02h last %0b, got %02h last %0b",
							$time, exp_word[7:0], exp_word[8], out_byte_o, out_last_o);
						errors++;
					end
				end
				delay = 0;
				if (slow_ack) draw_bits(ack_lfsr, 3, delay);
				repeat (delay) begin
					@(posedge clk);
					#2;
				end
				out_ack_i = 1'b1;
				do begin
					@(posedge clk);
					#2;
				end while (out_req_o);
				// late ack release, the drain must not raise a new request meanwhile
				delay = 0;
				if (slow_ack) draw_bits(ack_lfsr, 3, delay);
				repeat (delay) begin
					@(posedge clk);
					#2;
				end
				out_ack_i = 1'b0;
			end
		end
	end

	// handshake rules on both sides
	a_field_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(field_ack_o) |-> $past(field_req_i))
		else begin
			$display("field ack rose without a request at %0t", $time);
			errors++;
		end

	a_field_ack_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(field_ack_o) |-> !$past(field_req_i))
		else begin
			$display("field ack fell while the request was still high at %0t", $time);
			errors++;
		end

	a_out_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(out_req_o) |-> !$past(out_ack_i))
		else begin
			$display("output request rose while ack was high at %0t", $time);
			errors++;
		end

	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		(out_req_o && $past(out_req_o)) |-> ($stable(out_byte_o) && $stable(out_last_o)))
		else begin
			$display("output byte changed under an open request at %0t", $time);
			errors++;
		end

	initial begin : watchdog
		repeat (200 * TOTAL_FIELDS + 1000) @(posedge clk);
		$display("timeout: the run did not finish in time");
		$display("Verification failed");
		$finish;
	end

	initial begin : stimulus
		fix_proto_pkg::fix_field_t f;
		rst = 1'b1;
		field_req_i = 1'b0;
		field_i = '0;
		out_ack_i = 1'b0;
		slow_ack = 1'b0;
		stim_lfsr = 20'd99328;
		ack_lfsr = 20'd99328;
		msg_sum = 0;
		errors = 0;
		errs_before = 0;
		pass_count = 0;
		fail_count = 0;

		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		@(posedge clk);
		#2;
		assert (!out_req_o && !field_ack_o) else begin
			$display("Mismatch at %0t: handshake outputs not low after reset", $time);
			errors++;
		end
		close_test("reset");

		// tag "35", value "D", message stays open
		f = '0;
		f.tag[0] = "3";
		f.tag[1] = "5";
		f.tag_len = 3'd2;
		f.value[0] = "D";
		f.value_len = 5'd1;
		send_field(f);
		wait_drained();
		close_test("plain field");

		// tag "55", value "ABC", closes the first message
		f = '0;
		f.tag[0] = "5";
		f.tag[1] = "5";
		f.tag_len = 3'd2;
		f.value[0] = "A";
		f.value[1] = "B";
		f.value[2] = "C";
		f.value_len = 5'd3;
		f.last = 1'b1;
		send_field(f);
		wait_drained();
		close_test("checksum trailer");

		slow_ack = 1'b1;
		for (int n = 0; n < RAND_FIELDS; n++) begin
			random_field(n == RAND_FIELDS - 1, f);
			send_field(f);
		end
		wait_drained();
		close_test("random messages, slow ack");

		$display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
		if (fail_count == 0 && errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
